//--- alu.sv
`timescale 1ns/1ns

module alu (
    input  riscvPkg::word_t  a,
    input  riscvPkg::word_t  b,
    input  riscvPkg::aluOp_t aluOp,
    output riscvPkg::word_t  result,
    output logic             zero,
    output logic             negative
);
    import riscvPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'b0, lessThan};
            default: result = a + b;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = lessThan;          // Signed compare for blt rather than result sign

endmodule

//--- controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
    input  riscvPkg::word_t instrD,
    output riscvPkg::ctrl_t ctrlD
);
    import riscvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7Bit;
    logic       knownOp;

    assign opcode    = instrD[6:0];
    assign funct3    = instrD[14:12];
    assign funct7Bit = instrD[30];
    assign knownOp   = opcode inside {OP_R, OP_I, OP_LOAD, OP_STORE,
                                      OP_BRANCH, OP_JAL, OP_JALR, OP_LUI};

    function automatic aluOp_t aluDecode(logic [2:0] f3, logic isSub);
        case (f3)
            3'b000:  return isSub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrlD = '0;
        case (opcode)
            OP_R: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluOp    = aluDecode(funct3, funct7Bit);
            end
            OP_I: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluSrc   = 1'b1;
                ctrlD.aluOp    = aluDecode(funct3, 1'b0);   // No subi
                ctrlD.immSrc   = IMM_I;
            end
            OP_LOAD: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrc    = 1'b1;
                ctrlD.resultSrc = RES_MEM;
                ctrlD.immSrc    = IMM_I;
            end
            OP_STORE: begin
                ctrlD.memWrite = 1'b1;
                ctrlD.aluSrc   = 1'b1;
                ctrlD.immSrc   = IMM_S;
            end
            OP_BRANCH: begin
                ctrlD.branch = funct3 inside {3'b000, 3'b001, 3'b100};
                ctrlD.aluOp  = ALU_SUB;                      // Zero flag for eq/ne
                ctrlD.immSrc = IMM_B;
                case (funct3)
                    3'b001:  ctrlD.branchCond = BR_NE;
                    3'b100:  ctrlD.branchCond = BR_LT;
                    default: ctrlD.branchCond = BR_EQ;
                endcase
            end
            OP_JAL: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = RES_PC4;
                ctrlD.jump      = 1'b1;
                ctrlD.immSrc    = IMM_J;
            end
            OP_JALR: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrc    = 1'b1;
                ctrlD.resultSrc = RES_PC4;
                ctrlD.jump      = 1'b1;
                ctrlD.jumpReg   = 1'b1;
                ctrlD.immSrc    = IMM_I;
            end
            OP_LUI: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = RES_IMM;
                ctrlD.immSrc    = IMM_U;
            end
            default: ctrlD = '0;
        endcase
    end

    // Bubbles and junk words must stay harmless downstream
    always_comb begin
        unknownOpNoWrite: assert #0 (knownOp || !(ctrlD.regWrite || ctrlD.memWrite))
            else $error("controlUnit: opcode %b enables a write", opcode);
    end

endmodule

//--- dataMemory.sv
`timescale 1ns/1ns

module dataMemory (
    input  logic            clk,
    input  logic            memWrite,
    input  riscvPkg::word_t addr,
    input  riscvPkg::word_t wd,
    output riscvPkg::word_t rd
);
    import riscvPkg::*;

    logic [DMEM_ADDR_BITS-1:0] index;
    word_t                     mem [DMEM_WORDS];

    assign index = addr[DMEM_ADDR_BITS+1:2];   // Word aligned only

    always_ff @(posedge clk) begin
        if (memWrite)
            mem[index] <= wd;
    end

    assign rd = mem[index];

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
    input  riscvPkg::regAddr_t rs1D,
    input  riscvPkg::regAddr_t rs2D,
    input  riscvPkg::regAddr_t rs1E,
    input  riscvPkg::regAddr_t rs2E,
    input  riscvPkg::regAddr_t rdE,
    input  riscvPkg::regAddr_t rdM,
    input  riscvPkg::regAddr_t rdW,
    input  logic               regWriteM,
    input  logic               regWriteW,
    input  logic               loadE,
    input  logic               pcRedirectE,
    output logic [1:0]         forwardA,
    output logic [1:0]         forwardB,
    output logic               stallF,
    output logic               stallD,
    output logic               flushD,
    output logic               flushE
);
    import riscvPkg::*;

    logic loadUse;

    // Memory stage wins over writeback
    function automatic logic [1:0] fwdSel(regAddr_t rsE);
        if (regWriteM && rdM != '0 && rdM == rsE)
            return 2'd2;
        if (regWriteW && rdW != '0 && rdW == rsE)
            return 2'd1;
        return 2'd0;
    endfunction

    always_comb begin
        forwardA = fwdSel(rs1E);
        forwardB = fwdSel(rs2E);
    end

    assign loadUse = loadE && rdE != '0 && (rdE == rs1D || rdE == rs2D);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushD = pcRedirectE;
    assign flushE = loadUse || pcRedirectE;   // Bubble or killed slot

    always_comb begin
        decodeStallHoldsPc: assert #0 (!stallD || stallF)
            else $error("hazardUnit: decode stalled while fetch advances");
    end

endmodule

//--- instructionMemory.sv
`timescale 1ns/1ns

module instructionMemory (
    input  logic            clk,
    input  logic            progWrite,
    input  riscvPkg::word_t progAddr,
    input  riscvPkg::word_t progData,
    input  riscvPkg::word_t pc,
    output riscvPkg::word_t instr
);
    import riscvPkg::*;

    word_t mem [IMEM_WORDS];

    // Program load port takes a byte address
    always_ff @(posedge clk) begin
        if (progWrite)
            mem[progAddr[IMEM_ADDR_BITS+1:2]] <= progData;
    end

    assign instr = mem[pc[IMEM_ADDR_BITS+1:2]];

endmodule

//--- registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic               clk,
    input  logic               reset,
    input  logic               regWrite,
    input  riscvPkg::regAddr_t rs1,
    input  riscvPkg::regAddr_t rs2,
    input  riscvPkg::regAddr_t rd,
    input  riscvPkg::word_t    wd,
    output riscvPkg::word_t    rd1,
    output riscvPkg::word_t    rd2
);
    import riscvPkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (regWrite && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // Same-cycle write is bypassed to the readers
    function automatic word_t readPort(regAddr_t addr);
        if (addr == '0)
            return '0;
        if (regWrite && addr == rd)
            return wd;
        return regs[addr];
    endfunction

    always_comb begin
        rd1 = readPort(rs1);
        rd2 = readPort(rs2);
    end

endmodule

//--- riscvCore.sv
`timescale 1ns/1ns

module riscvCore (
    input  logic            clk,
    input  logic            reset,
    input  logic            progWrite,
    input  riscvPkg::word_t progAddr,
    input  riscvPkg::word_t progData,
    output logic            storeValid,
    output riscvPkg::word_t storeAddr,
    output riscvPkg::word_t storeData
);
    import riscvPkg::*;

    ctrl_t ctrlD;
    word_t instrD;
    word_t pcF;
    word_t instrF;
    word_t readData;

    controlUnit cu (
        .instrD(instrD), .ctrlD(ctrlD)
    );

    // Store port is the memory-stage write bus itself
    riscvDatapath dp (
        .clk(clk), .reset(reset), .ctrlD(ctrlD), .instrD(instrD),
        .pcF(pcF), .instrF(instrF),
        .dataAddr(storeAddr), .writeData(storeData), .memWrite(storeValid),
        .readData(readData)
    );

    instructionMemory imem (
        .clk(clk), .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .pc(pcF), .instr(instrF)
    );

    dataMemory dmem (
        .clk(clk), .memWrite(storeValid), .addr(storeAddr), .wd(storeData),
        .rd(readData)
    );

endmodule

//--- riscvCoreTb.sv
`timescale 1ns/1ns

module riscvCoreTb;
    import riscvPkg::*;

    localparam int    NUM_TESTS  = 5;
    localparam int    CLK_PERIOD = 100;
    localparam word_t END_ADDR   = 32'h0000_03FC;   // Last data word marks program end
    localparam word_t NOP        = 32'h0000_0013;   // addi x0, x0, 0

    logic        clk;
    logic        reset;
    logic        progWrite;
    word_t       progAddr;
    word_t       progData;
    logic        storeValid;
    word_t       storeAddr;
    word_t       storeData;

    word_t       prog[$];
    word_t       expAddr[$];
    word_t       expData[$];
    int          checks;
    int          errors;
    int          testErrors;
    int          testsRun;
    int          testsFailed;
    int unsigned seedValue;

    riscvCore DUT (
        .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .storeValid(storeValid), .storeAddr(storeAddr),
        .storeData(storeData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------
    // Instruction encoders

    function automatic word_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                                   logic [2:0] f3, regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                   regAddr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t encB(logic [12:0] off, regAddr_t rs2, regAddr_t rs1,
                                   logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t encJ(logic [20:0] off, regAddr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t encU(logic [19:0] upper, regAddr_t rd);
        return {upper, rd, OP_LUI};
    endfunction

    // Reference arithmetic
    function automatic word_t sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic word_t sltRef(word_t a, word_t b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    function automatic logic [11:0] randImm();
        logic [31:0] r;
        r = $urandom();
        return r[11:0];
    endfunction

    // --------------------------------------------------
    // Program building and checking

    task automatic emit(word_t w);
        prog.push_back(w);
    endtask

    task automatic expectStore(word_t addr, word_t data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic storeReg(regAddr_t rs2, logic [11:0] addr);
        emit(encS(addr, rs2, 5'd0));
    endtask

    // End marker store and then a spin in place
    task automatic emitEnd();
        storeReg(5'd0, END_ADDR[11:0]);
        expectStore(END_ADDR, '0);
        emit(encJ(21'd0, 5'd0));
        emit(NOP);
        emit(NOP);
    endtask

    task automatic driveEdge();
        @(posedge clk);
        #10;
    endtask

    task automatic checkAddr(word_t got, word_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("FAILED at %0t ns: %s address %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkData(word_t got, word_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("FAILED at %0t ns: %s data %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic runProgram(string name);
        word_t gotAddr[$];
        word_t gotData[$];
        int    n;
        bit    done;
        testErrors = 0;
        done       = 1'b0;
        driveEdge();
        reset      = 1'b1;
        repeat (3) driveEdge();
        foreach (prog[i]) begin                    // Load while the core sits in reset
            progWrite = 1'b1;
            progAddr  = 4 * i;
            progData  = prog[i];
            driveEdge();
        end
        progWrite = 1'b0;
        reset     = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (storeValid) begin
                gotAddr.push_back(storeAddr);
                gotData.push_back(storeData);
                if (storeAddr == END_ADDR)
                    done = 1'b1;
            end
        end
        n = (gotAddr.size() < expAddr.size()) ? gotAddr.size() : expAddr.size();
        if (gotAddr.size() != expAddr.size()) begin
            errors++;
            testErrors++;
            $display("%s: the core made %0d stores where %0d were expected",
                     name, gotAddr.size(), expAddr.size());
        end
        for (int i = 0; i < n; i++) begin
            checkAddr(gotAddr[i], expAddr[i], $sformatf("%s store %0d", name, i));
            checkData(gotData[i], expData[i], $sformatf("%s store %0d", name, i));
        end
        $display("%-10s done: %0d stores, %0d errors", name, gotAddr.size(), testErrors);
        testsRun++;
        if (testErrors != 0)
            testsFailed++;
        prog.delete();
        expAddr.delete();
        expData.delete();
    endtask

    // --------------------------------------------------
    // Tests

    task automatic aluChainTest();
        logic [11:0] c[6];
        word_t       v[13];
        for (int i = 0; i < 6; i++)
            c[i] = randImm();
        v[0]  = '0;
        v[1]  = sext12(c[0]);
        v[2]  = sext12(c[1]);
        v[3]  = v[1] + v[2];
        v[4]  = v[1] - v[3];
        v[5]  = v[4] & v[3];
        v[6]  = v[5] | v[4];
        v[7]  = v[6] ^ v[5];
        v[8]  = sltRef(v[7], v[6]);
        v[9]  = v[7] ^ sext12(c[2]);
        v[10] = v[9] & sext12(c[3]);
        v[11] = v[10] | sext12(c[4]);
        v[12] = sltRef(v[11], sext12(c[5]));
        emit(encI(c[0], 5'd0, 3'b000, 5'd1, OP_I));
        emit(encI(c[1], 5'd0, 3'b000, 5'd2, OP_I));
        emit(encR(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));   // add
        emit(encR(7'b0100000, 5'd3, 5'd1, 3'b000, 5'd4));   // sub
        emit(encR(7'b0000000, 5'd3, 5'd4, 3'b111, 5'd5));
        emit(encR(7'b0000000, 5'd4, 5'd5, 3'b110, 5'd6));
        emit(encR(7'b0000000, 5'd5, 5'd6, 3'b100, 5'd7));
        emit(encR(7'b0000000, 5'd6, 5'd7, 3'b010, 5'd8));   // slt
        emit(encI(c[2], 5'd7, 3'b100, 5'd9, OP_I));
        emit(encI(c[3], 5'd9, 3'b111, 5'd10, OP_I));
        emit(encI(c[4], 5'd10, 3'b110, 5'd11, OP_I));
        emit(encI(c[5], 5'd11, 3'b010, 5'd12, OP_I));       // slti
        for (int r = 3; r <= 12; r++) begin
            word_t slotAddr;
            slotAddr = 32'h100 + 4 * (r - 3);
            storeReg(r[4:0], slotAddr[11:0]);
            expectStore(slotAddr, v[r]);
        end
        emitEnd();
        runProgram("aluChain");
    endtask

    task automatic loadUseTest();
        logic [11:0] c;
        logic [11:0] k;
        word_t       v;
        c = randImm();
        k = randImm();
        v = sext12(c);
        emit(encI(c, 5'd0, 3'b000, 5'd1, OP_I));
        storeReg(5'd1, 12'h040);
        emit(encI(12'h040, 5'd0, 3'b010, 5'd2, OP_LOAD));
        emit(encI(k, 5'd2, 3'b000, 5'd3, OP_I));            // Uses the load at once
        storeReg(5'd3, 12'h044);
        emit(encI(12'h040, 5'd0, 3'b010, 5'd4, OP_LOAD));
        storeReg(5'd4, 12'h048);                              // Load feeds store data
        emit(encI(12'h044, 5'd0, 3'b010, 5'd5, OP_LOAD));
        emit(encR(7'b0000000, 5'd1, 5'd5, 3'b000, 5'd6));
        storeReg(5'd6, 12'h04C);
        expectStore(32'h40, v);
        expectStore(32'h44, v + sext12(k));
        expectStore(32'h48, v);
        expectStore(32'h4C, v + sext12(k) + v);
        emitEnd();
        runProgram("loadUse");
    endtask

    task automatic branchTest();
        emit(encI(12'd5, 5'd0, 3'b000, 5'd1, OP_I));
        emit(encI(12'd5, 5'd0, 3'b000, 5'd2, OP_I));
        emit(encI(12'hFFD, 5'd0, 3'b000, 5'd3, OP_I));       // -3
        emit(encB(13'd12, 5'd2, 5'd1, 3'b000));              // beq taken
        storeReg(5'd1, 12'h080);
        storeReg(5'd1, 12'h084);
        storeReg(5'd1, 12'h088);
        emit(encB(13'd8, 5'd2, 5'd1, 3'b001));               // bne not taken
        storeReg(5'd2, 12'h08C);
        emit(encB(13'd12, 5'd3, 5'd1, 3'b001));              // bne taken
        storeReg(5'd2, 12'h090);
        storeReg(5'd2, 12'h094);
        storeReg(5'd3, 12'h098);
        emit(encB(13'd12, 5'd1, 5'd3, 3'b100));              // blt taken as -3 < 5
        storeReg(5'd3, 12'h09C);
        storeReg(5'd3, 12'h0A0);
        storeReg(5'd3, 12'h0A4);
        emit(encB(13'd8, 5'd3, 5'd1, 3'b100));               // blt not taken
        storeReg(5'd1, 12'h0A8);
        emit(encB(13'd8, 5'd3, 5'd1, 3'b000));               // beq not taken
        storeReg(5'd3, 12'h0AC);
        expectStore(32'h88, 32'd5);
        expectStore(32'h8C, 32'd5);
        expectStore(32'h98, 32'hFFFF_FFFD);
        expectStore(32'hA4, 32'hFFFF_FFFD);
        expectStore(32'hA8, 32'd5);
        expectStore(32'hAC, 32'hFFFF_FFFD);
        emitEnd();
        runProgram("branch");
    endtask

    task automatic jumpTest();
        word_t linkJal;
        word_t linkJalr;
        emit(encI(12'd1, 5'd0, 3'b000, 5'd5, OP_I));
        linkJal = 4 * prog.size() + 4;
        emit(encJ(21'd12, 5'd1));                             // Skips two stores
        storeReg(5'd5, 12'h0C0);
        storeReg(5'd5, 12'h0C4);
        storeReg(5'd1, 12'h0C8);
        emit(encI(12'd36, 5'd0, 3'b000, 5'd6, OP_I));
        linkJalr = 4 * prog.size() + 4;
        emit(encI(12'd4, 5'd6, 3'b000, 5'd7, OP_JALR));       // Target 40
        storeReg(5'd5, 12'h0CC);
        storeReg(5'd5, 12'h0D0);
        storeReg(5'd5, 12'h0D4);
        storeReg(5'd7, 12'h0D8);
        expectStore(32'hC8, linkJal);
        expectStore(32'hD8, linkJalr);
        emitEnd();
        runProgram("jump");
    endtask

    task automatic luiZeroTest();
        logic [19:0] upper;
        logic [11:0] c;
        logic [31:0] r;
        r     = $urandom();
        upper = r[19:0];
        c     = randImm();
        emit(encU(upper, 5'd1));
        emit(encI(c, 5'd1, 3'b000, 5'd2, OP_I));
        storeReg(5'd2, 12'h0E0);
        storeReg(5'd1, 12'h0E4);
        emit(encI(12'd123, 5'd0, 3'b000, 5'd0, OP_I));       // Writes to x0 are dropped
        emit(encR(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd0));
        storeReg(5'd0, 12'h0E8);
        emit(encI(12'd7, 5'd0, 3'b000, 5'd3, OP_I));
        storeReg(5'd3, 12'h0EC);
        expectStore(32'hE0, {upper, 12'b0} + sext12(c));
        expectStore(32'hE4, {upper, 12'b0});
        expectStore(32'hE8, 32'd0);
        expectStore(32'hEC, 32'd7);
        emitEnd();
        runProgram("luiZero");
    endtask

    // --------------------------------------------------
    // Run control

    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("Watchdog expired: a test never stored to the end address");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        progWrite   = 1'b0;
        progAddr    = '0;
        progData    = '0;
        checks      = 0;
        errors      = 0;
        testErrors  = 0;
        testsRun    = 0;
        testsFailed = 0;
        seedValue   = $urandom(54);
        aluChainTest();
        loadUseTest();
        branchTest();
        jumpTest();
        luiZeroTest();
        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- riscvDatapath.sv
`timescale 1ns/1ns

module riscvDatapath (
    input  logic            clk,
    input  logic            reset,
    input  riscvPkg::ctrl_t ctrlD,
    output riscvPkg::word_t instrD,
    output riscvPkg::word_t pcF,
    input  riscvPkg::word_t instrF,
    output riscvPkg::word_t dataAddr,
    output riscvPkg::word_t writeData,
    output logic            memWrite,
    input  riscvPkg::word_t readData
);
    import riscvPkg::*;

    typedef struct packed {
        word_t pc;
        word_t pcPlus4;
        word_t instr;
    } ifId_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        word_t    pcPlus4;
        word_t    rd1;
        word_t    rd2;
        word_t    imm;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
    } idEx_t;

    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        resultSrc_t resultSrc;
        word_t      aluResult;
        word_t      writeData;
        word_t      pcPlus4;
        word_t      imm;
        regAddr_t   rd;
    } exMem_t;

    typedef struct packed {
        logic       regWrite;
        resultSrc_t resultSrc;
        word_t      aluResult;
        word_t      readData;
        word_t      pcPlus4;
        word_t      imm;
        regAddr_t   rd;
    } memWb_t;

    ifId_t      ifId;
    idEx_t      idEx;
    exMem_t     exMem;
    memWb_t     memWb;
    word_t      pcPlus4F;
    word_t      pcNext;
    word_t      rd1D;
    word_t      rd2D;
    word_t      immD;
    regAddr_t   rs1D;
    regAddr_t   rs2D;
    regAddr_t   rdD;
    word_t      srcAE;
    word_t      srcBE;
    word_t      writeDataE;
    word_t      aluResultE;
    word_t      pcTargetE;
    logic       zeroE;
    logic       negativeE;
    logic       takenE;
    logic       pcRedirectE;
    word_t      fwdM;
    word_t      resultW;
    logic [1:0] forwardA;
    logic [1:0] forwardB;
    logic       stallF;
    logic       stallD;
    logic       flushD;
    logic       flushE;

    function automatic word_t immGen(immSrc_t sel, word_t i);
        case (sel)
            IMM_S:   return {{20{i[31]}}, i[31:25], i[11:7]};
            IMM_B:   return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            IMM_J:   return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            IMM_U:   return {i[31:12], 12'b0};
            default: return {{20{i[31]}}, i[31:20]};
        endcase
    endfunction

    function automatic word_t pickResult(resultSrc_t sel, word_t alu, word_t mem,
                                         word_t pc4, word_t imm);
        case (sel)
            RES_MEM: return mem;
            RES_PC4: return pc4;
            RES_IMM: return imm;
            default: return alu;
        endcase
    endfunction

    function automatic word_t fwdMux(logic [1:0] sel, word_t base, word_t wb, word_t mem);
        case (sel)
            2'd1:    return wb;
            2'd2:    return mem;
            default: return base;
        endcase
    endfunction

    // --------------------------------------------------
    // Fetch
    assign pcPlus4F = pcF + 32'd4;
    assign pcNext   = !pcRedirectE      ? pcPlus4F :
                      idEx.ctrl.jumpReg ? {aluResultE[31:1], 1'b0} : pcTargetE;

    always_ff @(posedge clk) begin
        if (reset)
            pcF <= '0;
        else if (!stallF)
            pcF <= pcNext;
    end

    always_ff @(posedge clk) begin
        if (reset || flushD)
            ifId <= '0;
        else if (!stallD)
            ifId <= '{pc: pcF, pcPlus4: pcPlus4F, instr: instrF};
    end

    // --------------------------------------------------
    // Decode
    assign instrD = ifId.instr;
    assign rdD    = instrD[11:7];
    assign rs1D   = instrD[19:15];
    assign rs2D   = instrD[24:20];
    assign immD   = immGen(ctrlD.immSrc, instrD);

    registerFile rf (
        .clk(clk), .reset(reset), .regWrite(memWb.regWrite),
        .rs1(rs1D), .rs2(rs2D), .rd(memWb.rd), .wd(resultW),
        .rd1(rd1D), .rd2(rd2D)
    );

    always_ff @(posedge clk) begin
        if (reset || flushE)
            idEx <= '0;                               // Bubble never writes
        else
            idEx <= '{ctrl: ctrlD, pc: ifId.pc, pcPlus4: ifId.pcPlus4, rd1: rd1D,
                      rd2: rd2D, imm: immD, rs1: rs1D, rs2: rs2D, rd: rdD};
    end

    // --------------------------------------------------
    // Execute
    assign srcAE      = fwdMux(forwardA, idEx.rd1, resultW, fwdM);
    assign writeDataE = fwdMux(forwardB, idEx.rd2, resultW, fwdM);
    assign srcBE      = idEx.ctrl.aluSrc ? idEx.imm : writeDataE;
    assign pcTargetE  = idEx.pc + idEx.imm;

    alu aluE (
        .a(srcAE), .b(srcBE), .aluOp(idEx.ctrl.aluOp),
        .result(aluResultE), .zero(zeroE), .negative(negativeE)
    );

    always_comb begin
        case (idEx.ctrl.branchCond)
            BR_EQ:   takenE = idEx.ctrl.branch && zeroE;
            BR_NE:   takenE = idEx.ctrl.branch && !zeroE;
            BR_LT:   takenE = idEx.ctrl.branch && negativeE;
            default: takenE = 1'b0;
        endcase
    end
    assign pcRedirectE = takenE || idEx.ctrl.jump;

    always_ff @(posedge clk) begin
        if (reset)
            exMem <= '0;
        else
            exMem <= '{regWrite: idEx.ctrl.regWrite, memWrite: idEx.ctrl.memWrite,
                       resultSrc: idEx.ctrl.resultSrc, aluResult: aluResultE,
                       writeData: writeDataE, pcPlus4: idEx.pcPlus4, imm: idEx.imm,
                       rd: idEx.rd};
    end

    // --------------------------------------------------
    // Memory
    assign dataAddr  = exMem.aluResult;
    assign writeData = exMem.writeData;
    assign memWrite  = exMem.memWrite;
    // The load-use stall keeps a load here away from execute
    assign fwdM = pickResult(exMem.resultSrc, exMem.aluResult, exMem.aluResult,
                             exMem.pcPlus4, exMem.imm);

    always_ff @(posedge clk) begin
        if (reset)
            memWb <= '0;
        else
            memWb <= '{regWrite: exMem.regWrite, resultSrc: exMem.resultSrc,
                       aluResult: exMem.aluResult, readData: readData,
                       pcPlus4: exMem.pcPlus4, imm: exMem.imm, rd: exMem.rd};
    end

    // Writeback
    assign resultW = pickResult(memWb.resultSrc, memWb.aluResult, memWb.readData,
                                memWb.pcPlus4, memWb.imm);

    hazardUnit hu (
        .rs1D(rs1D), .rs2D(rs2D), .rs1E(idEx.rs1), .rs2E(idEx.rs2),
        .rdE(idEx.rd), .rdM(exMem.rd), .rdW(memWb.rd),
        .regWriteM(exMem.regWrite), .regWriteW(memWb.regWrite),
        .loadE(idEx.ctrl.resultSrc == RES_MEM), .pcRedirectE(pcRedirectE),
        .forwardA(forwardA), .forwardB(forwardB),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
    );

    // Redirect must also kill the slot entering execute
    redirectKillsExecute: assert property (@(posedge clk) disable iff (reset)
        (pcRedirectE && (stallF || flushD)) |-> flushE)
        else $error("riscvDatapath: redirect without execute flush");

endmodule

//--- riscvPkg.sv
package riscvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [2:0]  aluOp_t;
    typedef logic [1:0]  resultSrc_t;
    typedef logic [2:0]  immSrc_t;

    // --------------------------------------------------
    // Opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam aluOp_t ALU_ADD = 3'd0;
    localparam aluOp_t ALU_SUB = 3'd1;
    localparam aluOp_t ALU_AND = 3'd2;
    localparam aluOp_t ALU_OR  = 3'd3;
    localparam aluOp_t ALU_XOR = 3'd4;
    localparam aluOp_t ALU_SLT = 3'd5;

    localparam resultSrc_t RES_ALU = 2'd0;
    localparam resultSrc_t RES_MEM = 2'd1;
    localparam resultSrc_t RES_PC4 = 2'd2;
    localparam resultSrc_t RES_IMM = 2'd3;   // lui

    localparam immSrc_t IMM_I = 3'd0;
    localparam immSrc_t IMM_S = 3'd1;
    localparam immSrc_t IMM_B = 3'd2;
    localparam immSrc_t IMM_J = 3'd3;
    localparam immSrc_t IMM_U = 3'd4;

    localparam logic [1:0] BR_EQ = 2'd0;
    localparam logic [1:0] BR_NE = 2'd1;
    localparam logic [1:0] BR_LT = 2'd2;

    localparam int IMEM_WORDS     = 256;
    localparam int DMEM_WORDS     = 256;
    localparam int IMEM_ADDR_BITS = 8;
    localparam int DMEM_ADDR_BITS = 8;

    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       aluSrc;      // Immediate as operand B
        resultSrc_t resultSrc;
        aluOp_t     aluOp;
        logic       branch;
        logic [1:0] branchCond;
        logic       jump;
        logic       jumpReg;     // jalr
        immSrc_t    immSrc;
    } ctrl_t;

endpackage

//--- src.f
riscvPkg.sv
controlUnit.sv
registerFile.sv
alu.sv
hazardUnit.sv
riscvDatapath.sv
instructionMemory.sv
dataMemory.sv
riscvCore.sv
riscvCoreTb.sv
